// ==== Bender.yml ====
package:
  name: axi_cut_monitor

sources:
  - rtl/axi_lite_pkg.sv
  - rtl/chan_spill_reg.sv
  - rtl/axi_lite_cut.sv
  - rtl/chan_fifo.sv
  - rtl/axi_chan_compare.sv
  - rtl/cmp_status_wb.sv
  - rtl/axi_cut_monitor_top.sv
  - target: simulation
    files:
      - verification/axi_cut_monitor_chk.sv
      - verification/tb_axi_cut_monitor.sv

// ==== list.f ====
rtl/axi_lite_pkg.sv
rtl/chan_spill_reg.sv
rtl/axi_lite_cut.sv
rtl/chan_fifo.sv
rtl/axi_chan_compare.sv
rtl/cmp_status_wb.sv
rtl/axi_cut_monitor_top.sv
verification/axi_cut_monitor_chk.sv
verification/tb_axi_cut_monitor.sv

// ==== rtl/axi_chan_compare.sv ====
// in-order check per channel, err_clr also flushes the FIFOs so clear only while the link is idle
`timescale 1ns/1ps

module axi_chan_compare import axi_lite_pkg::*; (
    input  logic              clk_a_i,
    input  logic              rst_n,
    input  logic              a_aw_valid,
    input  logic              a_aw_ready,
    input  logic [ADDR_W-1:0] a_aw_addr,
    input  logic [PROT_W-1:0] a_aw_prot,
    input  logic              a_w_valid,
    input  logic              a_w_ready,
    input  logic [DATA_W-1:0] a_w_data,
    input  logic [STRB_W-1:0] a_w_strb,
    input  logic              a_b_valid,
    input  logic              a_b_ready,
    input  logic [RESP_W-1:0] a_b_resp,
    input  logic              a_ar_valid,
    input  logic              a_ar_ready,
    input  logic [ADDR_W-1:0] a_ar_addr,
    input  logic [PROT_W-1:0] a_ar_prot,
    input  logic              a_r_valid,
    input  logic              a_r_ready,
    input  logic [DATA_W-1:0] a_r_data,
    input  logic [RESP_W-1:0] a_r_resp,
    input  logic              b_aw_valid,
    input  logic              b_aw_ready,
    input  logic [ADDR_W-1:0] b_aw_addr,
    input  logic [PROT_W-1:0] b_aw_prot,
    input  logic              b_w_valid,
    input  logic              b_w_ready,
    input  logic [DATA_W-1:0] b_w_data,
    input  logic [STRB_W-1:0] b_w_strb,
    input  logic              b_b_valid,
    input  logic              b_b_ready,
    input  logic [RESP_W-1:0] b_b_resp,
    input  logic              b_ar_valid,
    input  logic              b_ar_ready,
    input  logic [ADDR_W-1:0] b_ar_addr,
    input  logic [PROT_W-1:0] b_ar_prot,
    input  logic              b_r_valid,
    input  logic              b_r_ready,
    input  logic [DATA_W-1:0] b_r_data,
    input  logic [RESP_W-1:0] b_r_resp,
    input  logic              err_clr,
    output logic [4:0]        err,
    output logic [CNT_W-1:0]  beat_cnt
);

    logic [AW_W-1:0] aw_head;
    logic [W_W-1:0]  w_head;
    logic [B_W-1:0]  b_head;
    logic [AR_W-1:0] ar_head;
    logic [R_W-1:0]  r_head;
    // exit handshakes and mismatches, indexed by chan_e
    logic [4:0]      fire_d;
    logic [4:0]      mis_d;
    logic [4:0]      fire_q;
    logic [4:0]      mis_q;

    assign fire_d[CH_AW] = b_aw_valid & b_aw_ready;
    assign fire_d[CH_W]  = b_w_valid & b_w_ready;
    assign fire_d[CH_B]  = a_b_valid & a_b_ready;
    assign fire_d[CH_AR] = b_ar_valid & b_ar_ready;
    assign fire_d[CH_R]  = a_r_valid & a_r_ready;

    assign mis_d[CH_AW] = fire_d[CH_AW] & ({b_aw_addr, b_aw_prot} != aw_head);
    assign mis_d[CH_W]  = fire_d[CH_W] & ({b_w_data, b_w_strb} != w_head);
    assign mis_d[CH_B]  = fire_d[CH_B] & (a_b_resp != b_head);
    assign mis_d[CH_AR] = fire_d[CH_AR] & ({b_ar_addr, b_ar_prot} != ar_head);
    assign mis_d[CH_R]  = fire_d[CH_R] & ({a_r_data, a_r_resp} != r_head);

    // requests are recorded at A
    chan_fifo #(.WIDTH(AW_W)) aw_fifo (
        .clk_a_i(clk_a_i), .rst_n(rst_n), .clr(err_clr),
        .push(a_aw_valid & a_aw_ready), .push_data({a_aw_addr, a_aw_prot}),
        .pop(fire_d[CH_AW]), .head(aw_head)
    );

    chan_fifo #(.WIDTH(W_W)) w_fifo (
        .clk_a_i(clk_a_i), .rst_n(rst_n), .clr(err_clr),
        .push(a_w_valid & a_w_ready), .push_data({a_w_data, a_w_strb}),
        .pop(fire_d[CH_W]), .head(w_head)
    );

    chan_fifo #(.WIDTH(AR_W)) ar_fifo (
        .clk_a_i(clk_a_i), .rst_n(rst_n), .clr(err_clr),
        .push(a_ar_valid & a_ar_ready), .push_data({a_ar_addr, a_ar_prot}),
        .pop(fire_d[CH_AR]), .head(ar_head)
    );

    // responses are recorded at B
    chan_fifo #(.WIDTH(B_W)) b_fifo (
        .clk_a_i(clk_a_i), .rst_n(rst_n), .clr(err_clr),
        .push(b_b_valid & b_b_ready), .push_data(b_b_resp),
        .pop(fire_d[CH_B]), .head(b_head)
    );

    chan_fifo #(.WIDTH(R_W)) r_fifo (
        .clk_a_i(clk_a_i), .rst_n(rst_n), .clr(err_clr),
        .push(b_r_valid & b_r_ready), .push_data({b_r_data, b_r_resp}),
        .pop(fire_d[CH_R]), .head(r_head)
    );

    // results land one edge after the exit handshake
    always_ff @(posedge clk_a_i) begin
        if (!rst_n || err_clr) begin
            fire_q   <= '0;
            mis_q    <= '0;
            err      <= '0;
            beat_cnt <= '0;
        end else begin
            fire_q   <= fire_d;
            mis_q    <= mis_d;
            err      <= err | mis_q;
            beat_cnt <= beat_cnt + CNT_W'($countones(fire_q));
        end
    end

endmodule

// ==== rtl/axi_cut_monitor_top.sv ====
// single clock, comparator FIFOs assume the cut holds no more than two beats per channel
`timescale 1ns/1ps

module axi_cut_monitor_top import axi_lite_pkg::*; (
    input  logic              clk_a_i,
    input  logic              rst_n,
    input  logic              a_aw_valid,
    output logic              a_aw_ready,
    input  logic [ADDR_W-1:0] a_aw_addr,
    input  logic [PROT_W-1:0] a_aw_prot,
    input  logic              a_w_valid,
    output logic              a_w_ready,
    input  logic [DATA_W-1:0] a_w_data,
    input  logic [STRB_W-1:0] a_w_strb,
    output logic              a_b_valid,
    input  logic              a_b_ready,
    output logic [RESP_W-1:0] a_b_resp,
    input  logic              a_ar_valid,
    output logic              a_ar_ready,
    input  logic [ADDR_W-1:0] a_ar_addr,
    input  logic [PROT_W-1:0] a_ar_prot,
    output logic              a_r_valid,
    input  logic              a_r_ready,
    output logic [DATA_W-1:0] a_r_data,
    output logic [RESP_W-1:0] a_r_resp,
    output logic              b_aw_valid,
    input  logic              b_aw_ready,
    output logic [ADDR_W-1:0] b_aw_addr,
    output logic [PROT_W-1:0] b_aw_prot,
    output logic              b_w_valid,
    input  logic              b_w_ready,
    output logic [DATA_W-1:0] b_w_data,
    output logic [STRB_W-1:0] b_w_strb,
    input  logic              b_b_valid,
    output logic              b_b_ready,
    input  logic [RESP_W-1:0] b_b_resp,
    output logic              b_ar_valid,
    input  logic              b_ar_ready,
    output logic [ADDR_W-1:0] b_ar_addr,
    output logic [PROT_W-1:0] b_ar_prot,
    input  logic              b_r_valid,
    output logic              b_r_ready,
    input  logic [DATA_W-1:0] b_r_data,
    input  logic [RESP_W-1:0] b_r_resp,
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  logic [1:0]        wb_adr,
    input  logic [DATA_W-1:0] wb_dat_i,
    input  logic [STRB_W-1:0] wb_sel,
    output logic [DATA_W-1:0] wb_dat_o,
    output logic              wb_ack
);

    // comparator to register block
    logic [4:0]        err;
    logic [CNT_W-1:0]  beat_cnt;
    logic              err_clr;
    // register block to cut
    logic [DATA_W-1:0] inj_mask;
    logic              inj_arm;
    logic              inj_done;

    // port and internal names match one to one
    axi_lite_cut axi_lite_cut_inst (.*);

    // taps both sides of the cut, after the W fault injection
    axi_chan_compare axi_chan_compare_inst (.*);

    cmp_status_wb cmp_status_wb_inst (.*);

endmodule

// ==== rtl/axi_lite_cut.sv ====
// AXI-Lite register slice on all five channels, W data flip applies to one beat per arm
`timescale 1ns/1ps

module axi_lite_cut import axi_lite_pkg::*; (
    input  logic              clk_a_i,
    input  logic              rst_n,
    // port A, manager side
    input  logic              a_aw_valid,
    output logic              a_aw_ready,
    input  logic [ADDR_W-1:0] a_aw_addr,
    input  logic [PROT_W-1:0] a_aw_prot,
    input  logic              a_w_valid,
    output logic              a_w_ready,
    input  logic [DATA_W-1:0] a_w_data,
    input  logic [STRB_W-1:0] a_w_strb,
    output logic              a_b_valid,
    input  logic              a_b_ready,
    output logic [RESP_W-1:0] a_b_resp,
    input  logic              a_ar_valid,
    output logic              a_ar_ready,
    input  logic [ADDR_W-1:0] a_ar_addr,
    input  logic [PROT_W-1:0] a_ar_prot,
    output logic              a_r_valid,
    input  logic              a_r_ready,
    output logic [DATA_W-1:0] a_r_data,
    output logic [RESP_W-1:0] a_r_resp,
    // port B, subordinate side
    output logic              b_aw_valid,
    input  logic              b_aw_ready,
    output logic [ADDR_W-1:0] b_aw_addr,
    output logic [PROT_W-1:0] b_aw_prot,
    output logic              b_w_valid,
    input  logic              b_w_ready,
    output logic [DATA_W-1:0] b_w_data,
    output logic [STRB_W-1:0] b_w_strb,
    input  logic              b_b_valid,
    output logic              b_b_ready,
    input  logic [RESP_W-1:0] b_b_resp,
    output logic              b_ar_valid,
    input  logic              b_ar_ready,
    output logic [ADDR_W-1:0] b_ar_addr,
    output logic [PROT_W-1:0] b_ar_prot,
    input  logic              b_r_valid,
    output logic              b_r_ready,
    input  logic [DATA_W-1:0] b_r_data,
    input  logic [RESP_W-1:0] b_r_resp,
    // fault injection
    input  logic [DATA_W-1:0] inj_mask,
    input  logic              inj_arm,
    output logic              inj_done
);

    logic [AW_W-1:0] aw_out;
    logic [W_W-1:0]  w_out;
    logic [AR_W-1:0] ar_out;
    logic [R_W-1:0]  r_out;

    chan_spill_reg #(.WIDTH(AW_W)) aw_slice (
        .clk_a_i(clk_a_i), .rst_n(rst_n),
        .in_valid(a_aw_valid), .in_ready(a_aw_ready), .in_data({a_aw_addr, a_aw_prot}),
        .out_valid(b_aw_valid), .out_ready(b_aw_ready), .out_data(aw_out)
    );

    chan_spill_reg #(.WIDTH(W_W)) w_slice (
        .clk_a_i(clk_a_i), .rst_n(rst_n),
        .in_valid(a_w_valid), .in_ready(a_w_ready), .in_data({a_w_data, a_w_strb}),
        .out_valid(b_w_valid), .out_ready(b_w_ready), .out_data(w_out)
    );

    // responses run from B back to A
    chan_spill_reg #(.WIDTH(B_W)) b_slice (
        .clk_a_i(clk_a_i), .rst_n(rst_n),
        .in_valid(b_b_valid), .in_ready(b_b_ready), .in_data(b_b_resp),
        .out_valid(a_b_valid), .out_ready(a_b_ready), .out_data(a_b_resp)
    );

    chan_spill_reg #(.WIDTH(AR_W)) ar_slice (
        .clk_a_i(clk_a_i), .rst_n(rst_n),
        .in_valid(a_ar_valid), .in_ready(a_ar_ready), .in_data({a_ar_addr, a_ar_prot}),
        .out_valid(b_ar_valid), .out_ready(b_ar_ready), .out_data(ar_out)
    );

    chan_spill_reg #(.WIDTH(R_W)) r_slice (
        .clk_a_i(clk_a_i), .rst_n(rst_n),
        .in_valid(b_r_valid), .in_ready(b_r_ready), .in_data({b_r_data, b_r_resp}),
        .out_valid(a_r_valid), .out_ready(a_r_ready), .out_data(r_out)
    );

    assign b_aw_addr = aw_out[AW_W-1:PROT_W];
    assign b_aw_prot = aw_out[PROT_W-1:0];
    assign b_ar_addr = ar_out[AR_W-1:PROT_W];
    assign b_ar_prot = ar_out[PROT_W-1:0];
    assign a_r_data  = r_out[R_W-1:RESP_W];
    assign a_r_resp  = r_out[RESP_W-1:0];

    // corrupt the head W beat while armed, strobes stay intact
    assign b_w_data = inj_arm ? (w_out[W_W-1:STRB_W] ^ inj_mask) : w_out[W_W-1:STRB_W];
    assign b_w_strb = w_out[STRB_W-1:0];
    assign inj_done = inj_arm & b_w_valid & b_w_ready;

endmodule

// ==== rtl/axi_lite_pkg.sv ====
// single clock domain, AXI-Lite subset only (no bursts, IDs or user bits), FIFO_DEPTH >= 3
package axi_lite_pkg;

    // AXI-Lite field widths
    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 32;
    localparam int unsigned STRB_W = DATA_W / 8;
    localparam int unsigned PROT_W = 3;
    localparam int unsigned RESP_W = 2;

    // bundled channel payloads, msb first as {addr, prot}, {data, strb}, {data, resp}
    localparam int unsigned AW_W = ADDR_W + PROT_W;
    localparam int unsigned AR_W = ADDR_W + PROT_W;
    localparam int unsigned W_W  = DATA_W + STRB_W;
    localparam int unsigned B_W  = RESP_W;
    localparam int unsigned R_W  = DATA_W + RESP_W;

    // expected beats per channel, the cut holds at most two
    localparam int unsigned FIFO_DEPTH = 4;

    localparam int unsigned CNT_W = 16;

    // bit positions in the error vector
    typedef enum logic [2:0] {
        CH_AW = 3'd0,
        CH_W  = 3'd1,
        CH_B  = 3'd2,
        CH_AR = 3'd3,
        CH_R  = 3'd4
    } chan_e;

    // wishbone word addresses
    typedef enum logic [1:0] {
        REG_STATUS = 2'd0,
        REG_COUNT  = 2'd1,
        REG_INJECT = 2'd2,
        REG_CLEAR  = 2'd3
    } reg_addr_e;

    typedef enum logic {
        WB_IDLE = 1'b0,
        WB_ACK  = 1'b1
    } wb_state_e;

endpackage

// ==== rtl/chan_fifo.sv ====
// no full or empty flags, the user keeps occupancy at or below FIFO_DEPTH
`timescale 1ns/1ps

module chan_fifo import axi_lite_pkg::*; #(
    parameter int unsigned WIDTH = 8
) (
    input  logic             clk_a_i,
    input  logic             rst_n,
    input  logic             push,
    input  logic [WIDTH-1:0] push_data,
    input  logic             pop,
    output logic [WIDTH-1:0] head,
    input  logic             clr
);

    logic [WIDTH-1:0]              mem [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;

    assign head = mem[rd_ptr];

    always_ff @(posedge clk_a_i) begin
        if (!rst_n || clr) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_a_i) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

// ==== rtl/chan_spill_reg.sv ====
// full-throughput two-entry slice, in_ready comes from a flop only, one cycle latency when empty
`timescale 1ns/1ps

module chan_spill_reg #(
    parameter int unsigned WIDTH = 8
) (
    input  logic             clk_a_i,
    input  logic             rst_n,
    input  logic             in_valid,
    output logic             in_ready,
    input  logic [WIDTH-1:0] in_data,
    output logic             out_valid,
    input  logic             out_ready,
    output logic [WIDTH-1:0] out_data
);

    logic             main_valid;
    logic [WIDTH-1:0] main_data;
    logic             spill_valid;
    logic [WIDTH-1:0] spill_data;
    logic             in_fire;
    logic             main_free;

    // only the spill entry decides whether a new beat can come in
    assign in_ready  = ~spill_valid;
    assign in_fire   = in_valid & in_ready;

    // main entry empty or draining this cycle
    assign main_free = ~main_valid | out_ready;

    assign out_valid = main_valid;
    assign out_data  = main_data;

    always_ff @(posedge clk_a_i) begin
        if (!rst_n) begin
            main_valid  <= 1'b0;
            spill_valid <= 1'b0;
        end else if (main_free) begin
            // the older spilled beat goes first, in_fire is low while it is held
            main_valid  <= spill_valid | in_fire;
            spill_valid <= 1'b0;
        end else if (in_fire) begin
            spill_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk_a_i) begin
        if (main_free) begin
            main_data <= spill_valid ? spill_data : in_data;
        end
        // output stalled, park the incoming beat
        if (!main_free && in_fire) begin
            spill_data <= in_data;
        end
    end

endmodule

// ==== rtl/cmp_status_wb.sv ====
// Wishbone classic, one wait state per access, wb_sel applies to REG_INJECT writes only
`timescale 1ns/1ps

module cmp_status_wb import axi_lite_pkg::*; (
    input  logic              clk_a_i,
    input  logic              rst_n,
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  logic [1:0]        wb_adr,
    input  logic [DATA_W-1:0] wb_dat_i,
    input  logic [STRB_W-1:0] wb_sel,
    output logic [DATA_W-1:0] wb_dat_o,
    output logic              wb_ack,
    input  logic [4:0]        err,
    input  logic [CNT_W-1:0]  beat_cnt,
    output logic              err_clr,
    output logic [DATA_W-1:0] inj_mask,
    output logic              inj_arm,
    input  logic              inj_done
);

    wb_state_e state;
    reg_addr_e reg_sel;
    logic      wr_en;

    assign reg_sel = reg_addr_e'(wb_adr);
    assign wb_ack  = (state == WB_ACK);
    // writes commit on the ack cycle
    assign wr_en   = wb_ack & wb_we;
    assign err_clr = wr_en & (reg_sel == REG_CLEAR);

    always_ff @(posedge clk_a_i) begin
        if (!rst_n) begin
            state <= WB_IDLE;
        end else begin
            case (state)
                WB_IDLE: begin
                    if (wb_cyc && wb_stb) begin
                        state <= WB_ACK;
                    end
                end
                default: state <= WB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_a_i) begin
        if (!rst_n) begin
            inj_arm  <= 1'b0;
            inj_mask <= '0;
        end else if (wr_en && reg_sel == REG_INJECT) begin
            // a new arm wins over a done from the previous one
            inj_arm <= 1'b1;
            for (int i = 0; i < STRB_W; i++) begin
                if (wb_sel[i]) begin
                    inj_mask[8*i +: 8] <= wb_dat_i[8*i +: 8];
                end
            end
        end else if (inj_done) begin
            inj_arm <= 1'b0;
        end
    end

    always_comb begin
        wb_dat_o = '0;
        case (reg_sel)
            REG_STATUS: wb_dat_o[4:0] = err;
            REG_COUNT:  wb_dat_o[CNT_W-1:0] = beat_cnt;
            REG_INJECT: wb_dat_o = inj_mask;
            // clear is write-only
            default:    wb_dat_o = '0;
        endcase
    end

endmodule

// ==== verification/axi_cut_monitor_chk.sv ====
// checks only the outputs of the cut, A-side request inputs are driven by the testbench
`timescale 1ns/1ps

module axi_cut_monitor_chk import axi_lite_pkg::*; (
    input logic            clk_a_i,
    input logic            rst_n,
    // exit side valids and readies, indexed by chan_e
    input logic [4:0]      out_valid,
    input logic [4:0]      out_ready,
    input logic [AW_W-1:0] aw_pay,
    input logic [W_W-1:0]  w_pay,
    input logic [AR_W-1:0] ar_pay,
    input logic [B_W-1:0]  b_pay,
    input logic [R_W-1:0]  r_pay
);

    for (genvar i = 0; i < 5; i++) begin : g_hold
        assert property (@(posedge clk_a_i) disable iff (!rst_n)
            out_valid[i] && !out_ready[i] |=> out_valid[i])
            else $error("valid on channel %0d dropped before its beat transferred", i);
    end

    assert property (@(posedge clk_a_i) disable iff (!rst_n)
        out_valid[CH_AW] && !out_ready[CH_AW] |=> $stable(aw_pay))
        else $error("AW payload changed while stalled");
    assert property (@(posedge clk_a_i) disable iff (!rst_n)
        out_valid[CH_W] && !out_ready[CH_W] |=> $stable(w_pay))
        else $error("W payload changed while stalled");
    assert property (@(posedge clk_a_i) disable iff (!rst_n)
        out_valid[CH_AR] && !out_ready[CH_AR] |=> $stable(ar_pay))
        else $error("AR payload changed while stalled");
    assert property (@(posedge clk_a_i) disable iff (!rst_n)
        out_valid[CH_B] && !out_ready[CH_B] |=> $stable(b_pay))
        else $error("B payload changed while stalled");
    assert property (@(posedge clk_a_i) disable iff (!rst_n)
        out_valid[CH_R] && !out_ready[CH_R] |=> $stable(r_pay))
        else $error("R payload changed while stalled");

    // synchronous reset clears every output valid
    assert property (@(posedge clk_a_i) !rst_n |=> out_valid == '0)
        else $error("output valid high during reset");

endmodule

bind axi_lite_cut axi_cut_monitor_chk axi_cut_monitor_chk_inst (
    .clk_a_i(clk_a_i),
    .rst_n(rst_n),
    .out_valid({a_r_valid, b_ar_valid, a_b_valid, b_w_valid, b_aw_valid}),
    .out_ready({a_r_ready, b_ar_ready, a_b_ready, b_w_ready, b_aw_ready}),
    .aw_pay({b_aw_addr, b_aw_prot}),
    .w_pay({b_w_data, b_w_strb}),
    .ar_pay({b_ar_addr, b_ar_prot}),
    .b_pay(a_b_resp),
    .r_pay({a_r_data, a_r_resp})
);

// ==== verification/cut_golden.txt ====
// columns op f1 f2 f3 f4 f5 in hex; op 1 write: addr prot wdata strb bresp; op 2 read: addr prot rdata rresp 0
// op 3 wishbone read: reg expected 0 0 0; op 4 wishbone write: reg value 0 0 0; op 0 ends the table
1 00001000 0 deadbeef f 0
1 00001004 2 01234567 3 0
2 00001000 0 cafef00d 0 0
1 00002000 5 a5a5a5a5 c 2
2 00003008 1 13579bdf 1 0
2 0000300c 7 2468ace0 3 3
1 00004000 0 0f0f0f0f f 0
3 0 0 0 0 0
3 1 12 0 0 0
4 2 00ff0010 0 0 0
3 2 00ff0010 0 0 0
1 00005000 0 11111111 f 0
3 0 2 0 0 0
1 00005004 0 22222222 f 1
3 0 2 0 0 0
3 1 18 0 0 0
4 3 0 0 0 0
3 0 0 0 0 0
3 1 0 0 0 0
2 00006000 4 89abcdef 2 0
3 1 2 0 0 0
3 0 0 0 0 0
0 0 0 0 0 0

// ==== verification/tb_axi_cut_monitor.sv ====
// one AXI transaction in flight at a time, golden table read from the project root, stops at first error
`timescale 1ns/1ps

module tb_axi_cut_monitor import axi_lite_pkg::*; ();

    localparam int REC_W   = 6;
    localparam int MAX_REC = 64;

    logic clk_a_i;
    logic rst_n;
    logic a_aw_valid, a_aw_ready, a_w_valid, a_w_ready, a_b_valid, a_b_ready;
    logic a_ar_valid, a_ar_ready, a_r_valid, a_r_ready;
    logic b_aw_valid, b_aw_ready, b_w_valid, b_w_ready, b_b_valid, b_b_ready;
    logic b_ar_valid, b_ar_ready, b_r_valid, b_r_ready;
    logic [ADDR_W-1:0] a_aw_addr, a_ar_addr, b_aw_addr, b_ar_addr;
    logic [PROT_W-1:0] a_aw_prot, a_ar_prot, b_aw_prot, b_ar_prot;
    logic [DATA_W-1:0] a_w_data, b_w_data, a_r_data, b_r_data;
    logic [STRB_W-1:0] a_w_strb, b_w_strb, wb_sel;
    logic [RESP_W-1:0] a_b_resp, b_b_resp, a_r_resp, b_r_resp;
    logic wb_cyc, wb_stb, wb_we, wb_ack;
    logic [1:0] wb_adr;
    logic [DATA_W-1:0] wb_dat_i, wb_dat_o;

    logic [31:0] gold [REC_W*MAX_REC];
    // expected beats per channel, in order
    logic [63:0] exp_aw[$], exp_w[$], exp_ar[$], exp_b[$], exp_r[$];
    // handshakes seen on each side, indexed by chan_e
    int cnt_a [5];
    int cnt_b [5];
    int n_rec;
    int n_wr;
    int n_rd;
    int model_cnt;
    bit loaded;
    logic [DATA_W-1:0] inj_pend;

    axi_cut_monitor_top axi_cut_monitor_top_inst (.*);

    initial clk_a_i = 1'b0;
    always #5 clk_a_i = ~clk_a_i;

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic do_write(input logic [31:0] addr, prot, data, strb, resp);
        exp_aw.push_back({addr[ADDR_W-1:0], prot[PROT_W-1:0]});
        // an armed mask flips this beat only
        exp_w.push_back({data ^ inj_pend, strb[STRB_W-1:0]});
        exp_b.push_back(resp[RESP_W-1:0]);
        inj_pend = '0;
        n_wr++;
        @(negedge clk_a_i);
        a_aw_valid = 1'b1;
        a_aw_addr  = addr;
        a_aw_prot  = prot[PROT_W-1:0];
        a_w_valid  = 1'b1;
        a_w_data   = data;
        a_w_strb   = strb[STRB_W-1:0];
        fork
            begin
                wait (cnt_a[CH_AW] == n_wr);
                @(negedge clk_a_i);
                a_aw_valid = 1'b0;
            end
            begin
                wait (cnt_a[CH_W] == n_wr);
                @(negedge clk_a_i);
                a_w_valid = 1'b0;
            end
        join
        // subordinate answers once address and data have arrived
        wait (cnt_b[CH_AW] == n_wr && cnt_b[CH_W] == n_wr);
        @(negedge clk_a_i);
        b_b_valid = 1'b1;
        b_b_resp  = resp[RESP_W-1:0];
        wait (cnt_b[CH_B] == n_wr);
        @(negedge clk_a_i);
        b_b_valid = 1'b0;
        wait (cnt_a[CH_B] == n_wr);
    endtask

    task automatic do_read(input logic [31:0] addr, prot, data, resp);
        exp_ar.push_back({addr[ADDR_W-1:0], prot[PROT_W-1:0]});
        exp_r.push_back({data, resp[RESP_W-1:0]});
        n_rd++;
        @(negedge clk_a_i);
        a_ar_valid = 1'b1;
        a_ar_addr  = addr;
        a_ar_prot  = prot[PROT_W-1:0];
        wait (cnt_a[CH_AR] == n_rd);
        @(negedge clk_a_i);
        a_ar_valid = 1'b0;
        wait (cnt_b[CH_AR] == n_rd);
        @(negedge clk_a_i);
        b_r_valid = 1'b1;
        b_r_data  = data;
        b_r_resp  = resp[RESP_W-1:0];
        wait (cnt_b[CH_R] == n_rd);
        @(negedge clk_a_i);
        b_r_valid = 1'b0;
        wait (cnt_a[CH_R] == n_rd);
    endtask

    task automatic wb_access(input logic we, input logic [1:0] adr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
        int waits;
        waits = 0;
        @(negedge clk_a_i);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_i = wdata;
        do begin
            @(posedge clk_a_i);
            waits++;
        end while (!wb_ack);
        rdata = wb_dat_o;
        check_val("wb_ack delay", waits, 2);
        @(negedge clk_a_i);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        // ack lasts a single cycle
        check_val("wb_ack", wb_ack, 1'b0);
    endtask

    // beat counters and in-order payload checks at the exit ports
    always @(posedge clk_a_i) begin
        if (rst_n) begin
            cnt_a[CH_AW] += int'(a_aw_valid && a_aw_ready);
            cnt_a[CH_W]  += int'(a_w_valid && a_w_ready);
            cnt_a[CH_B]  += int'(a_b_valid && a_b_ready);
            cnt_a[CH_AR] += int'(a_ar_valid && a_ar_ready);
            cnt_a[CH_R]  += int'(a_r_valid && a_r_ready);
            cnt_b[CH_AW] += int'(b_aw_valid && b_aw_ready);
            cnt_b[CH_W]  += int'(b_w_valid && b_w_ready);
            cnt_b[CH_B]  += int'(b_b_valid && b_b_ready);
            cnt_b[CH_AR] += int'(b_ar_valid && b_ar_ready);
            cnt_b[CH_R]  += int'(b_r_valid && b_r_ready);
            if (b_aw_valid && b_aw_ready) begin
                if (exp_aw.size() == 0) stop_on_error("AW beat left port B with nothing sent");
                check_val("b_aw_addr/b_aw_prot", {b_aw_addr, b_aw_prot}, exp_aw.pop_front());
            end
            if (b_w_valid && b_w_ready) begin
                if (exp_w.size() == 0) stop_on_error("W beat left port B with nothing sent");
                check_val("b_w_data/b_w_strb", {b_w_data, b_w_strb}, exp_w.pop_front());
            end
            if (b_ar_valid && b_ar_ready) begin
                if (exp_ar.size() == 0) stop_on_error("AR beat left port B with nothing sent");
                check_val("b_ar_addr/b_ar_prot", {b_ar_addr, b_ar_prot}, exp_ar.pop_front());
            end
            if (a_b_valid && a_b_ready) begin
                if (exp_b.size() == 0) stop_on_error("B beat left port A with nothing sent");
                check_val("a_b_resp", a_b_resp, exp_b.pop_front());
            end
            if (a_r_valid && a_r_ready) begin
                if (exp_r.size() == 0) stop_on_error("R beat left port A with nothing sent");
                check_val("a_r_data/a_r_resp", {a_r_data, a_r_resp}, exp_r.pop_front());
            end
        end
    end

    initial begin
        loaded = 1'b0;
        wait (loaded);
        repeat (n_rec * 200 + 10) @(posedge clk_a_i);
        stop_on_error("timeout, the golden table did not complete in 200 cycles per line");
    end

    initial begin
        logic [31:0] op;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;
        logic [31:0] f5;
        logic [31:0] rdata;
        int unsigned first_draw;
        first_draw = $urandom(32'h66c8_3014);
        rst_n = 1'b0;
        {a_aw_valid, a_w_valid, a_ar_valid, a_b_ready, a_r_ready} = '0;
        {a_aw_addr, a_aw_prot, a_ar_addr, a_ar_prot, a_w_data, a_w_strb} = '0;
        {b_aw_ready, b_w_ready, b_ar_ready, b_b_valid, b_r_valid} = '0;
        {b_b_resp, b_r_data, b_r_resp} = '0;
        {wb_cyc, wb_stb, wb_we, wb_adr, wb_dat_i} = '0;
        wb_sel = '1;
        inj_pend = '0;
        $readmemh("verification/cut_golden.txt", gold);
        n_rec = 0;
        while (n_rec < MAX_REC && gold[n_rec*REC_W] inside {[1:4]}) begin
            n_rec++;
        end
        if (n_rec == 0) stop_on_error("golden table is missing or empty");
        loaded = 1'b1;
        repeat (2) @(posedge clk_a_i);
        @(negedge clk_a_i);
        rst_n = 1'b1;
        // random stalls on the B-side request readies and the A-side response readies
        fork
            forever begin
                @(negedge clk_a_i);
                b_aw_ready = 1'($urandom % 2);
                b_w_ready  = 1'($urandom % 2);
                b_ar_ready = 1'($urandom % 2);
                a_b_ready  = 1'($urandom % 2);
                a_r_ready  = 1'($urandom % 2);
            end
        join_none
        for (int i = 0; i < n_rec; i++) begin
            op = gold[i*REC_W];
            f1 = gold[i*REC_W+1];
            f2 = gold[i*REC_W+2];
            f3 = gold[i*REC_W+3];
            f4 = gold[i*REC_W+4];
            f5 = gold[i*REC_W+5];
            case (op)
                1: begin
                    do_write(f1, f2, f3, f4, f5);
                    model_cnt += 3;
                end
                2: begin
                    do_read(f1, f2, f3, f4);
                    model_cnt += 2;
                end
                3: begin
                    wb_access(1'b0, f1[1:0], '0, rdata);
                    check_val($sformatf("wb_dat_o reg %0d", f1), rdata, f2);
                    if (f1 == REG_COUNT) check_val("wb_dat_o beat count", rdata, model_cnt);
                end
                default: begin
                    wb_access(1'b1, f1[1:0], f2, rdata);
                    if (f1 == REG_INJECT) inj_pend = f2;
                    if (f1 == REG_CLEAR) model_cnt = 0;
                end
            endcase
        end
        repeat (4) @(posedge clk_a_i);
        for (int ch = 0; ch < 5; ch++) begin
            check_val($sformatf("cnt_b[%0d]", ch), cnt_b[ch], cnt_a[ch]);
        end
        $display("TEST PASS");
        $finish;
    end

endmodule
